// ==== tests/mvp_input.txt ====
# p <instruction word hex>                 program, in order from pc 0
# w <register hex> <vector hex, lane 3 first>  expected writebacks, in order
p 70807fff
p 71000003
p 11844000
p 22082000
p 32844000
p 930000a5
p 4398a000
p 54188000
p 64986000
p 85180000
p 85980400
p 86180800
p 86980c00
p a0010123
p 00000000
p 97000123
p 17b9c000
p a001e124
p 98000124
w 01 7fff7fff7fff7fff
w 02 0003000300030003
w 03 8002800280028002
w 04 8004800480048004
w 05 7ffd7ffd7ffd7ffd
w 06 506f506e506d506c
w 07 506d506c506d506c
w 08 d06fd06ed06dd06c
w 09 d06dd06cd06fd06e
w 0a 506c506d506e506f
w 0b 506c506f506e506d
w 0c 506c506c506c506c
w 0d 506e506f506c506d
w 0e d06fd06ed06dd06c
w 0f a0dea0dca0daa0d8
w 10 a0dea0dca0daa0d8

// ==== all.f ====
design/mvp_pkg.sv
design/instruction_fetch.sv
design/decoder.sv
design/vrf.sv
design/vector_alu.sv
design/vector_permute.sv
design/mvp_core.sv
tests/mvp_core_sva.sv
tests/mvp_core_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -j 0
TOP       := mvp_core_tb
FILELIST  := all.f
OBJ_DIR   := obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o $(TOP)
	./$(OBJ_DIR)/$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// ==== tests/mvp_core_tb.sv ====
`timescale 1ns/1ps

module mvp_core_tb;

    localparam int LANES    = 4;
    localparam int LANE_W   = 16;
    localparam int VEC_W    = LANES * LANE_W;
    localparam int PC_W     = 8;
    localparam int ADR_W    = 12;
    localparam int DRAIN    = 20;

    typedef struct packed {
        logic [4:0]       vd;
        logic [VEC_W-1:0] data;
    } wb_beat_t;

    logic                             clk;
    logic                             rst_n;
    logic                             en;
    logic [PC_W-1:0]                  pc;
    logic [31:0]                      instr;
    logic                             wb_cyc;
    logic                             wb_stb;
    logic                             wb_we;
    logic [ADR_W-1:0]                 wb_adr;
    logic [LANES-1:0][LANE_W-1:0]     wb_dat_o;
    logic [LANES-1:0][LANE_W-1:0]     wb_dat_i;
    logic                             wb_ack;
    logic                             data_out_vld;
    logic [LANES-1:0][LANE_W-1:0]     data_out;
    logic [4:0]                       reg_wb;

    logic [31:0]      rom [2**PC_W];
    logic [VEC_W-1:0] ram [logic [ADR_W-1:0]];
    wb_beat_t         exp_q [$];
    wb_beat_t         beat;
    int               prog_len;
    int               wait_left;
    logic             busy;

    mvp_core #(
        .VECTOR_LANES (LANES ),
        .LANE_WIDTH   (LANE_W),
        .PC_WIDTH     (PC_W  )
    ) i_mvp_core (
        .clk          (clk         ),
        .rst_n        (rst_n       ),
        .en           (en          ),
        .pc           (pc          ),
        .instr        (instr       ),
        .wb_cyc       (wb_cyc      ),
        .wb_stb       (wb_stb      ),
        .wb_we        (wb_we       ),
        .wb_adr       (wb_adr      ),
        .wb_dat_o     (wb_dat_o    ),
        .wb_dat_i     (wb_dat_i    ),
        .wb_ack       (wb_ack      ),
        .data_out_vld (data_out_vld),
        .data_out     (data_out    ),
        .reg_wb       (reg_wb      )
    );

    // Zero words in the instruction ROM decode as nop
    assign instr = rom[pc];

    initial begin
        clk = 1'b0;
        forever begin
            #20 clk = ~clk;
        end
    end

    task automatic fail_now(input string reason);
        $display("%s", reason);
        $display("tests failed");
        $fatal(1, "run stopped");
    endtask

    task automatic check_value(input string name, input logic [VEC_W-1:0] got,
                               input logic [VEC_W-1:0] exp);
        if (got !== exp) begin
            $display("Error: %s got 0x%h expected 0x%h", name, got, exp);
            $display("tests failed");
            $fatal(1, "value mismatch");
        end
    endtask

    // Untouched addresses read a pattern built from the address and the lane
    function automatic logic [VEC_W-1:0] mem_read(input logic [ADR_W-1:0] adr);
        logic [VEC_W-1:0] v;
        if (ram.exists(adr)) begin
            return ram[adr];
        end
        for (int i = 0; i < LANES; i++) begin
            v[i*LANE_W +: LANE_W] = {adr, 4'(i)} ^ 16'h5a3c;
        end
        return v;
    endfunction

    task automatic load_input_file();
        int         fd;
        int         n;
        string      line;
        logic [7:0] tag;
        logic [63:0] a;
        logic [63:0] b;
        wb_beat_t    e;
        fd = $fopen("tests/mvp_input.txt", "r");
        if (fd == 0) begin
            fail_now("cannot open the data file tests/mvp_input.txt");
        end
        prog_len = 0;
        while (!$feof(fd)) begin
            n = $fgets(line, fd);
            if (n > 1 && line[0] != "#") begin
                n = $sscanf(line, "%c %h %h", tag, a, b);
                if (tag == "p") begin
                    rom[prog_len] = a[31:0];
                    prog_len++;
                end else if (tag == "w") begin
                    e.vd   = a[4:0];
                    e.data = b;
                    exp_q.push_back(e);
                end
            end
        end
        $fclose(fd);
    endtask

    //====================
    // Wishbone slave
    //====================

    always @(posedge clk) begin
        logic             ack_next;
        logic [VEC_W-1:0] rdata;
        ack_next = 1'b0;
        rdata    = wb_dat_i;
        if (wb_ack) begin
            busy = 1'b0;
        end else if (wb_cyc && wb_stb) begin
            if (!busy) begin
                busy      = 1'b1;
                wait_left = int'($urandom % 4);
            end
            if (wait_left == 0) begin
                ack_next = 1'b1;
                if (wb_we) begin
                    ram[wb_adr] = wb_dat_o;
                end else begin
                    rdata = mem_read(wb_adr);
                end
            end else begin
                wait_left--;
            end
        end
        wb_ack   <= #2 ack_next;
        wb_dat_i <= #2 rdata;
    end

    //====================
    // Writeback monitor
    //====================

    always @(posedge clk) begin
        if (!rst_n) begin
            if (data_out_vld === 1'b1) begin
                fail_now("writeback beat seen while reset is asserted");
            end
        end else if (data_out_vld) begin
            if (exp_q.size() == 0) begin
                fail_now("writeback beat seen with no expected entry left");
            end
            beat = exp_q.pop_front();
            check_value("reg_wb", VEC_W'(reg_wb), VEC_W'(beat.vd));
            check_value("data_out", data_out, beat.data);
        end
    end

    initial begin
        int cycles;
        int limit;
        void'($urandom(32'hc49c_dcf1));
        rst_n    = 1'b0;
        en       = 1'b0;
        wb_ack   = 1'b0;
        wb_dat_i = '0;
        busy     = 1'b0;
        for (int i = 0; i < 2**PC_W; i++) begin
            rom[i] = 32'h0;
        end
        load_input_file();
        limit  = 5 * prog_len + 100;
        cycles = 0;

        repeat (4) @(posedge clk);
        #2;
        // Core enabled while reset is still held
        en = 1'b1;
        repeat (12) @(posedge clk);
        #2;
        rst_n = 1'b1;

        while (exp_q.size() > 0) begin
            @(posedge clk);
            cycles++;
            if (cycles > limit) begin
                fail_now("timeout waiting for the expected writebacks");
            end
        end
        // Let the tail run so stray beats are caught
        repeat (DRAIN) @(posedge clk);
        $display("all tests passed");
        $finish;
    end

endmodule

// ==== tests/mvp_core_sva.sv ====
`timescale 1ns/1ps

module mvp_core_sva (
    input logic clk,
    input logic rst_n,
    input logic wb_cyc,
    input logic wb_stb,
    input logic wb_ack,
    input logic data_out_vld
);

    stb_needs_cyc: assert property (
        @(posedge clk) disable iff (!rst_n) wb_stb |-> wb_cyc
    ) else $error("wb_stb high without wb_cyc");

    // Cycle may only end after an ack
    cyc_held_to_ack: assert property (
        @(posedge clk) disable iff (!rst_n) (wb_cyc && !wb_ack) |=> wb_cyc
    ) else $error("wb_cyc dropped before wb_ack");

    no_beat_in_reset: assert property (
        @(posedge clk) !rst_n |-> !data_out_vld
    ) else $error("data_out_vld high during reset");

endmodule

bind mvp_core mvp_core_sva i_sva (
    .clk          (clk         ),
    .rst_n        (rst_n       ),
    .wb_cyc       (wb_cyc      ),
    .wb_stb       (wb_stb      ),
    .wb_ack       (wb_ack      ),
    .data_out_vld (data_out_vld)
);

// ==== design/mvp_core.sv ====
`timescale 1ns/1ps

module mvp_core #(
    parameter int VECTOR_LANES = 4,
    parameter int LANE_WIDTH   = 16,
    parameter int PC_WIDTH     = 8
) (
    input  logic                                    clk,
    input  logic                                    rst_n,
    input  logic                                    en,

    output logic [PC_WIDTH-1:0]                     pc,
    input  logic [mvp_pkg::INSTR_W-1:0]             instr,

    output logic                                    wb_cyc,
    output logic                                    wb_stb,
    output logic                                    wb_we,
    output logic [mvp_pkg::MEM_ADDR_W-1:0]          wb_adr,
    output logic [VECTOR_LANES-1:0][LANE_WIDTH-1:0] wb_dat_o,
    input  logic [VECTOR_LANES-1:0][LANE_WIDTH-1:0] wb_dat_i,
    input  logic                                    wb_ack,

    output logic                                    data_out_vld,
    output logic [VECTOR_LANES-1:0][LANE_WIDTH-1:0] data_out,
    output logic [mvp_pkg::REG_ADDR_W-1:0]          reg_wb
);

    import mvp_pkg::*;

    typedef logic [VECTOR_LANES-1:0][LANE_WIDTH-1:0] vec_t;

    typedef struct packed {
        decoded_t dec;
        vec_t     a;
        vec_t     b;
    } ex_stage_t;

    typedef struct packed {
        logic [REG_ADDR_W-1:0] vd;
        logic                  reg_we;
        logic                  mem_we;
        logic                  mem_re;
        unit_e                 unit;
        logic [MEM_ADDR_W-1:0] mem_addr;
        vec_t                  alu_res;
        vec_t                  perm_res;
        vec_t                  st_data;
    } mem_stage_t;

    typedef struct packed {
        logic [REG_ADDR_W-1:0] vd;
        logic                  reg_we;
        vec_t                  data;
    } wb_stage_t;

    ex_stage_t  ex;
    mem_stage_t mem;
    wb_stage_t  wb;

    decoded_t dec;
    decoded_t dec_issue;
    logic     stall;
    logic     advance;
    vec_t     rd1;
    vec_t     rd2;
    vec_t     fwd_a;
    vec_t     fwd_b;
    vec_t     alu_out;
    vec_t     perm_out;
    vec_t     mem_result;
    vec_t     ld_hold;
    logic     mem_req;
    logic     mem_ack;
    logic     mem_wait;
    logic     mem_done;
    logic     ack_q;

    // Bus wait holds every stage
    assign advance = en & ~mem_wait;

    //====================
    // Fetch and decode
    //====================

    instruction_fetch #(
        .PC_WIDTH (PC_WIDTH)
    ) i_fetch (
        .clk   (clk    ),
        .rst_n (rst_n  ),
        .en    (advance),
        .stall (stall  ),
        .pc    (pc     )
    );

    decoder i_decoder (
        .instr      (instr        ),
        .ex_vd      (ex.dec.vd    ),
        .ex_is_load (ex.dec.mem_re),
        .dec        (dec          ),
        .stall      (stall        )
    );

    vrf #(
        .VECTOR_LANES (VECTOR_LANES),
        .LANE_WIDTH   (LANE_WIDTH  )
    ) i_vrf (
        .clk     (clk         ),
        .rst_n   (rst_n       ),
        .wen     (data_out_vld),
        .addr_w  (wb.vd       ),
        .addr_r1 (dec.vs1     ),
        .addr_r2 (dec.vs2     ),
        .data_w  (wb.data     ),
        .data_r1 (rd1         ),
        .data_r2 (rd2         )
    );

    // Load-use bubble
    always_comb begin
        dec_issue = dec;
        if (stall) begin
            dec_issue.op     = OP_NOP;
            dec_issue.reg_we = 1'b0;
            dec_issue.mem_we = 1'b0;
            dec_issue.mem_re = 1'b0;
        end
    end

    //====================
    // Execute
    //====================

    // Memory stage wins over writeback; loads there are never ready
    assign fwd_a = (mem.reg_we && mem.unit != UNIT_MEM && mem.vd == ex.dec.vs1) ? mem_result :
                   (wb.reg_we && wb.vd == ex.dec.vs1) ? wb.data : ex.a;
    assign fwd_b = (mem.reg_we && mem.unit != UNIT_MEM && mem.vd == ex.dec.vs2) ? mem_result :
                   (wb.reg_we && wb.vd == ex.dec.vs2) ? wb.data : ex.b;

    vector_alu #(
        .VECTOR_LANES (VECTOR_LANES),
        .LANE_WIDTH   (LANE_WIDTH  )
    ) i_alu (
        .op      (ex.dec.op ),
        .vec_a   (fwd_a     ),
        .vec_b   (fwd_b     ),
        .imm     (ex.dec.imm),
        .vec_out (alu_out   )
    );

    vector_permute #(
        .VECTOR_LANES (VECTOR_LANES),
        .LANE_WIDTH   (LANE_WIDTH  )
    ) i_permute (
        .funct   (ex.dec.funct),
        .vec_in  (fwd_a       ),
        .vec_out (perm_out    )
    );

    //====================
    // Memory
    //====================

    // One idle cycle after each ack keeps transfers apart
    assign mem_req  = mem.mem_re | mem.mem_we;
    assign wb_cyc   = mem_req & ~mem_done & ~ack_q;
    assign wb_stb   = wb_cyc;
    assign wb_we    = wb_cyc & mem.mem_we;
    assign wb_adr   = mem.mem_addr;
    assign wb_dat_o = mem.st_data;
    assign mem_ack  = wb_cyc & wb_ack;
    assign mem_wait = mem_req & ~mem_done & ~mem_ack;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mem_done <= 1'b0;
            ack_q    <= 1'b0;
        end else begin
            ack_q <= mem_ack;
            // Ack taken while frozen by en
            if (advance) begin
                mem_done <= 1'b0;
            end else if (mem_ack) begin
                mem_done <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (mem_ack) begin
            ld_hold <= wb_dat_i;
        end
    end

    always_comb begin
        case (mem.unit)
            UNIT_PERM: mem_result = mem.perm_res;
            UNIT_MEM:  mem_result = mem_done ? ld_hold : wb_dat_i;
            default:   mem_result = mem.alu_res;
        endcase
    end

    //====================
    // Writeback
    //====================

    // One beat per write, on the cycle the stage moves on
    assign data_out_vld = wb.reg_we & advance;
    assign data_out     = wb.data;
    assign reg_wb       = wb.vd;

    //====================
    // Stage registers
    //====================

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ex.dec.reg_we <= 1'b0;
            ex.dec.mem_we <= 1'b0;
            ex.dec.mem_re <= 1'b0;
            mem.reg_we    <= 1'b0;
            mem.mem_we    <= 1'b0;
            mem.mem_re    <= 1'b0;
            wb.reg_we     <= 1'b0;
        end else if (advance) begin
            ex.dec       <= dec_issue;
            ex.a         <= rd1;
            ex.b         <= rd2;

            mem.vd       <= ex.dec.vd;
            mem.reg_we   <= ex.dec.reg_we;
            mem.mem_we   <= ex.dec.mem_we;
            mem.mem_re   <= ex.dec.mem_re;
            mem.unit     <= ex.dec.unit;
            mem.mem_addr <= ex.dec.mem_addr;
            mem.alu_res  <= alu_out;
            mem.perm_res <= perm_out;
            mem.st_data  <= fwd_b;

            wb.vd        <= mem.vd;
            wb.reg_we    <= mem.reg_we;
            wb.data      <= mem_result;
        end
    end

endmodule

// ==== design/vector_permute.sv ====
`timescale 1ns/1ps

module vector_permute #(
    parameter int VECTOR_LANES = 4,
    parameter int LANE_WIDTH   = 16
) (
    input  mvp_pkg::perm_e                          funct,
    input  logic [VECTOR_LANES-1:0][LANE_WIDTH-1:0] vec_in,
    output logic [VECTOR_LANES-1:0][LANE_WIDTH-1:0] vec_out
);

    import mvp_pkg::*;

    always_comb begin
        for (int i = 0; i < VECTOR_LANES; i++) begin
            case (funct)
                PERM_REVERSE: begin
                    vec_out[i] = vec_in[VECTOR_LANES-1-i];
                end
                PERM_ROTATE: begin
                    vec_out[i] = vec_in[(i + 1) % VECTOR_LANES];
                end
                PERM_BROADCAST: begin
                    vec_out[i] = vec_in[0];
                end
                PERM_SWAP_PAIRS: begin
                    // Odd last lane has no partner
                    if ((i ^ 1) < VECTOR_LANES) begin
                        vec_out[i] = vec_in[i ^ 1];
                    end else begin
                        vec_out[i] = vec_in[i];
                    end
                end
                default: begin
                    vec_out[i] = vec_in[i];
                end
            endcase
        end
    end

endmodule

// ==== design/vector_alu.sv ====
`timescale 1ns/1ps

module vector_alu #(
    parameter int VECTOR_LANES = 4,
    parameter int LANE_WIDTH   = 16
) (
    input  mvp_pkg::vec_op_e                        op,
    input  logic [VECTOR_LANES-1:0][LANE_WIDTH-1:0] vec_a,
    input  logic [VECTOR_LANES-1:0][LANE_WIDTH-1:0] vec_b,
    input  logic [mvp_pkg::IMM_W-1:0]               imm,
    output logic [VECTOR_LANES-1:0][LANE_WIDTH-1:0] vec_out
);

    import mvp_pkg::*;

    logic [LANE_WIDTH-1:0] imm_lane;

    // Sign extended or truncated to one lane
    assign imm_lane = LANE_WIDTH'($signed(imm));

    // All results wrap at the lane width
    always_comb begin
        for (int i = 0; i < VECTOR_LANES; i++) begin
            case (op)
                OP_VADD: begin
                    vec_out[i] = vec_a[i] + vec_b[i];
                end
                OP_VSUB: begin
                    vec_out[i] = vec_a[i] - vec_b[i];
                end
                OP_VMUL: begin
                    // Low half of the product
                    vec_out[i] = vec_a[i] * vec_b[i];
                end
                OP_VAND: begin
                    vec_out[i] = vec_a[i] & vec_b[i];
                end
                OP_VOR: begin
                    vec_out[i] = vec_a[i] | vec_b[i];
                end
                OP_VXOR: begin
                    vec_out[i] = vec_a[i] ^ vec_b[i];
                end
                OP_VLI: begin
                    vec_out[i] = imm_lane;
                end
                default: begin
                    vec_out[i] = '0;
                end
            endcase
        end
    end

endmodule

// ==== design/vrf.sv ====
`timescale 1ns/1ps

module vrf #(
    parameter int VECTOR_LANES = 4,
    parameter int LANE_WIDTH   = 16
) (
    input  logic                                    clk,
    input  logic                                    rst_n,
    input  logic                                    wen,
    input  logic [mvp_pkg::REG_ADDR_W-1:0]          addr_w,
    input  logic [mvp_pkg::REG_ADDR_W-1:0]          addr_r1,
    input  logic [mvp_pkg::REG_ADDR_W-1:0]          addr_r2,
    input  logic [VECTOR_LANES-1:0][LANE_WIDTH-1:0] data_w,
    output logic [VECTOR_LANES-1:0][LANE_WIDTH-1:0] data_r1,
    output logic [VECTOR_LANES-1:0][LANE_WIDTH-1:0] data_r2
);

    import mvp_pkg::*;

    localparam int DEPTH = 2 ** REG_ADDR_W;

    logic [VECTOR_LANES-1:0][LANE_WIDTH-1:0] regs [DEPTH];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < DEPTH; i++) begin
                regs[i] <= '0;
            end
        end else if (wen) begin
            regs[addr_w] <= data_w;
        end
    end

    // Same-cycle write is visible to decode
    assign data_r1 = (wen && addr_w == addr_r1) ? data_w : regs[addr_r1];
    assign data_r2 = (wen && addr_w == addr_r2) ? data_w : regs[addr_r2];

endmodule

// ==== design/decoder.sv ====
`timescale 1ns/1ps

module decoder (
    input  logic [mvp_pkg::INSTR_W-1:0]    instr,
    input  logic [mvp_pkg::REG_ADDR_W-1:0] ex_vd,
    input  logic                           ex_is_load,
    output mvp_pkg::decoded_t              dec,
    output logic                           stall
);

    import mvp_pkg::*;

    vec_op_e op_raw;
    logic    rd_vs1;
    logic    rd_vs2;

    assign op_raw = vec_op_e'(instr[OP_LSB +: OP_W]);

    always_comb begin
        dec          = '0;
        dec.op       = op_raw;
        dec.vd       = instr[VD_LSB +: REG_ADDR_W];
        dec.vs1      = instr[VS1_LSB +: REG_ADDR_W];
        dec.vs2      = instr[VS2_LSB +: REG_ADDR_W];
        dec.funct    = perm_e'(instr[FUNCT_LSB +: PERM_W]);
        // Immediate overlaps vs2 and funct
        dec.imm      = instr[IMM_W-1:0];
        dec.mem_addr = instr[MEM_ADDR_W-1:0];
        dec.unit     = UNIT_ALU;
        rd_vs1       = 1'b0;
        rd_vs2       = 1'b0;

        case (op_raw)
            OP_VADD, OP_VSUB, OP_VMUL, OP_VAND, OP_VOR, OP_VXOR: begin
                dec.reg_we = 1'b1;
                rd_vs1     = 1'b1;
                rd_vs2     = 1'b1;
            end
            OP_VLI: begin
                dec.reg_we = 1'b1;
            end
            OP_VPERM: begin
                dec.reg_we = 1'b1;
                dec.unit   = UNIT_PERM;
                rd_vs1     = 1'b1;
            end
            OP_VLD: begin
                dec.reg_we = 1'b1;
                dec.mem_re = 1'b1;
                dec.unit   = UNIT_MEM;
            end
            OP_VST: begin
                // Store data comes from vs2
                dec.mem_we = 1'b1;
                rd_vs2     = 1'b1;
            end
            default: begin
                dec.op = OP_NOP;
            end
        endcase
    end

    // Load result is not ready until writeback
    assign stall = ex_is_load &&
                   ((rd_vs1 && dec.vs1 == ex_vd) || (rd_vs2 && dec.vs2 == ex_vd));

endmodule

// ==== design/instruction_fetch.sv ====
`timescale 1ns/1ps

module instruction_fetch #(
    parameter int PC_WIDTH = 8
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                en,
    input  logic                stall,
    output logic [PC_WIDTH-1:0] pc
);

    // Straight-line program, one word per cycle
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc <= '0;
        end else if (en && !stall) begin
            pc <= pc + PC_WIDTH'(1);
        end
    end

endmodule

// ==== design/mvp_pkg.sv ====
package mvp_pkg;

    localparam int INSTR_W    = 32;
    localparam int REG_ADDR_W = 5;
    localparam int OP_W       = 4;
    localparam int PERM_W     = 3;
    localparam int UNIT_W     = 2;
    localparam int IMM_W      = 16;
    localparam int MEM_ADDR_W = 12;

    // Instruction field positions
    localparam int OP_LSB    = 28;
    localparam int VD_LSB    = 23;
    localparam int VS1_LSB   = 18;
    localparam int VS2_LSB   = 13;
    localparam int FUNCT_LSB = 10;

    typedef enum logic [OP_W-1:0] {
        OP_NOP   = 4'd0,
        OP_VADD  = 4'd1,
        OP_VSUB  = 4'd2,
        OP_VMUL  = 4'd3,
        OP_VAND  = 4'd4,
        OP_VOR   = 4'd5,
        OP_VXOR  = 4'd6,
        OP_VLI   = 4'd7,
        OP_VPERM = 4'd8,
        OP_VLD   = 4'd9,
        OP_VST   = 4'd10
    } vec_op_e;

    typedef enum logic [PERM_W-1:0] {
        PERM_REVERSE    = 3'd0,
        PERM_ROTATE     = 3'd1,
        PERM_BROADCAST  = 3'd2,
        PERM_SWAP_PAIRS = 3'd3
    } perm_e;

    // Source of the writeback data
    typedef enum logic [UNIT_W-1:0] {
        UNIT_ALU  = 2'd0,
        UNIT_PERM = 2'd1,
        UNIT_MEM  = 2'd2
    } unit_e;

    typedef struct packed {
        vec_op_e                 op;
        logic [REG_ADDR_W-1:0]   vd;
        logic [REG_ADDR_W-1:0]   vs1;
        logic [REG_ADDR_W-1:0]   vs2;
        perm_e                   funct;
        logic [IMM_W-1:0]        imm;
        logic [MEM_ADDR_W-1:0]   mem_addr;
        logic                    reg_we;
        logic                    mem_we;
        logic                    mem_re;
        unit_e                   unit;
    } decoded_t;

endpackage
